// ==== frameStore.sv ====
`timescale 1ns/1ns

module frameStore import percVarPkg::*; #(
	parameter int order = lpcOrder
) (
	input  logic clk,
	input  logic load,
	input  logic [4:0] loadAddr,
	input  word16 loadData,
	input  logic rcIndex,
	input  logic gapSet,
	input  logic [3:0] gapIndex,
	output word16 rcWord,
	output word16 lsfLow,
	output word16 lsfHigh
);

	localparam int depth = 2 + 2 * order;	// Two coefficients and two LSF sets

	word16 mem [depth];
	int lowIdx;

	// Single write port, addresses past the map are dropped
	always_ff @(posedge clk)
	begin
		if (load && (int'(loadAddr) < depth))
			mem[loadAddr] <= loadData;
	end

	// Interpolated set starts at 2, new set right after it
	always_comb
	begin
		lowIdx = 2 + int'(gapSet) * order + int'(gapIndex);
	end

	assign rcWord = mem[rcIndex];
	assign lsfLow = mem[lowIdx];
	assign lsfHigh = mem[lowIdx + 1];

endmodule

// ==== larConvert.sv ====
`timescale 1ns/1ns

module larConvert import percVarPkg::*; (
	input  logic clk,
	input  logic reset,
	input  word16 rcIn,
	output word16 lar
);

	word16 absVal;
	word16 shifted;
	word16 halved;
	word16 slope;
	word16 larMag;
	word32 offset;
	word32 prod;
	word32 diffL;

	//////////////////////////////////////////////////////////////////////
	// Three-segment approximation on the magnitude
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		absVal = rcIn[15] ? satSub16(16'sd0, rcIn) : rcIn;	// -1.0 clips to max
		shifted = absVal >>> 4;
		halved = shifted >>> 1;

		if (shifted <= seg2)
		begin
			slope = slopeA1;
			offset = offsetB1;
		end
		else if (shifted <= seg3)
		begin
			slope = slopeA2;
			offset = offsetB2;
		end
		else
		begin
			slope = slopeA3;
			offset = offsetB3;
		end

		// Fractional product, small operands so no clipping needed
		prod = (word32'(halved) * word32'(slope)) <<< 1;
		diffL = prod - offset;

		if (shifted <= seg1)
			larMag = shifted;	// Linear region near zero
		else
			larMag = word16'(diffL >>> 11);	// Low word of the scaled result
	end

	// Sign restored on the way into the output register
	always_ff @(posedge clk)
	begin
		if (reset)
			lar <= '0;
		else if (rcIn[15])
			lar <= satSub16(16'sd0, larMag);
		else
			lar <= larMag;
	end

endmodule

// ==== lsfMinGap.sv ====
`timescale 1ns/1ns

module lsfMinGap import percVarPkg::*; #(
	parameter int order = lpcOrder
) (
	input  logic clk,
	input  logic reset,
	input  logic gapStart,
	input  word16 lsfLow,
	input  word16 lsfHigh,
	output logic [3:0] gapIndex,
	output word16 dMin,
	output logic gapDone
);

	localparam logic [3:0] lastIdx = 4'(order - 2);	// Index of the last pair

	logic running;
	word16 gap;

	// Gap between doubled neighbours, doubling is never written back
	always_comb
	begin
		gap = satSub16(shl16(lsfHigh, 1), shl16(lsfLow, 1));
	end

	//////////////////////////////////////////////////////////////////////
	// Pair counter, pair 0 is read in the start cycle
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			gapIndex <= '0;
			gapDone <= 1'b0;
		end
		else
		begin
			gapDone <= 1'b0;
			if (!running && gapStart)
			begin
				running <= 1'b1;
				gapIndex <= 4'd1;
			end
			else if (running)
			begin
				if (gapIndex == lastIdx)
				begin
					running <= 1'b0;
					gapIndex <= '0;	// Ready for the next search
					gapDone <= 1'b1;
				end
				else
					gapIndex <= gapIndex + 4'd1;
			end
		end
	end

	// Running minimum, seeded by the first pair
	always_ff @(posedge clk)
	begin
		if (!running && gapStart)
			dMin <= gap;
		else if (running && (gap < dMin))
			dMin <= gap;
	end

endmodule

// ==== percVar.sv ====
`timescale 1ns/1ns

module percVar import percVarPkg::*; #(
	parameter int order = lpcOrder
) (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic [4:0] loadAddr,
	input  word16 loadData,
	input  logic start,
	output logic busy,
	output logic done,
	output word16 gamma1Sf0,
	output word16 gamma1Sf1,
	output word16 gamma2Sf0,
	output word16 gamma2Sf1
);

	logic rcIndex;
	word16 rcWord;
	word16 rcOut;
	word16 lar;
	logic gapSet;
	logic [3:0] gapIndex;
	word16 lsfLow;
	word16 lsfHigh;
	logic gapStart;
	word16 dMin;
	logic gapDone;

	frameStore #(.order(order)) uStore (
		.clk(clk), .load(load), .loadAddr(loadAddr), .loadData(loadData),
		.rcIndex(rcIndex), .gapSet(gapSet), .gapIndex(gapIndex),
		.rcWord(rcWord), .lsfLow(lsfLow), .lsfHigh(lsfHigh)
	);

	larConvert uLar (
		.clk(clk), .reset(reset), .rcIn(rcOut), .lar(lar)
	);

	lsfMinGap #(.order(order)) uGap (
		.clk(clk), .reset(reset), .gapStart(gapStart),
		.lsfLow(lsfLow), .lsfHigh(lsfHigh),
		.gapIndex(gapIndex), .dMin(dMin), .gapDone(gapDone)
	);

	percVarCtrl uCtrl (
		.clk(clk), .reset(reset), .start(start),
		.rcWord(rcWord), .lar(lar), .dMin(dMin), .gapDone(gapDone),
		.rcIndex(rcIndex), .rcOut(rcOut), .gapStart(gapStart), .gapSet(gapSet),
		.busy(busy), .done(done),
		.gamma1Sf0(gamma1Sf0), .gamma1Sf1(gamma1Sf1),
		.gamma2Sf0(gamma2Sf0), .gamma2Sf1(gamma2Sf1)
	);

endmodule

// ==== percVarCtrl.sv ====
`timescale 1ns/1ns

module percVarCtrl import percVarPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  word16 rcWord,
	input  word16 lar,
	input  word16 dMin,
	input  logic gapDone,
	output logic rcIndex,
	output word16 rcOut,
	output logic gapStart,
	output logic gapSet,
	output logic busy,
	output logic done,
	output word16 gamma1Sf0,
	output word16 gamma1Sf1,
	output word16 gamma2Sf0,
	output word16 gamma2Sf1
);

	ctrlState state;
	logic sf;	// Current subframe
	logic smooth;
	logic smoothNext;
	word16 prevLar0;
	word16 prevLar1;
	word16 larNew0;
	word16 larNew1;
	word16 g1Pend [2];	// Results waiting for done
	word16 g2Pend [2];
	word16 avg0;
	word16 avg1;
	word16 crit0;
	word16 crit1;
	word16 g2Raw;
	word16 g2Clamp;

	assign rcIndex = (state == convert1);
	assign rcOut = rcWord;	// Converter input
	assign gapSet = sf;	// Interpolated set for subframe 0
	assign gapStart = (state == decide) && !smoothNext;

	//////////////////////////////////////////////////////////////////////
	// Subframe LARs, hysteresis and gamma2 arithmetic
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// lar holds the second new LAR during the first decide cycle
		avg0 = satAdd16(larNew0, prevLar0) >>> 1;
		avg1 = satAdd16(lar, prevLar1) >>> 1;
		crit0 = sf ? larNew0 : avg0;
		crit1 = sf ? larNew1 : avg1;

		if (smooth)
			smoothNext = !((crit0 < threshL1) && (crit1 > threshH1));
		else
			smoothNext = (crit0 > threshL2) || (crit1 < threshH2);

		g2Raw = shl16(satSub16(beta, mult16(alpha, dMin)), 5);
		if (g2Raw > gamma2Max)
			g2Clamp = gamma2Max;
		else if (g2Raw < gamma2Min)
			g2Clamp = gamma2Min;
		else
			g2Clamp = g2Raw;
	end

	//////////////////////////////////////////////////////////////////////
	// Frame sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			sf <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			smooth <= 1'b1;
			prevLar0 <= '0;
			prevLar1 <= '0;
			gamma1Sf0 <= '0;
			gamma1Sf1 <= '0;
			gamma2Sf0 <= '0;
			gamma2Sf1 <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
				begin
					if (start)
					begin
						busy <= 1'b1;
						sf <= 1'b0;
						state <= convert0;
					end
				end
				convert0: state <= convert1;
				convert1: state <= decide;
				decide:
				begin
					smooth <= smoothNext;
					if (!sf)
					begin
						prevLar0 <= larNew0;	// New LARs become next frame's old
						prevLar1 <= lar;
					end
					if (!smoothNext)
						state <= gapRun;
					else if (sf)
						state <= finish;
					else
						sf <= 1'b1;
				end
				gapRun:
				begin
					if (gapDone)
						state <= gammaCalc;
				end
				gammaCalc:
				begin
					if (sf)
						state <= finish;
					else
					begin
						sf <= 1'b1;
						state <= decide;
					end
				end
				finish:
				begin
					done <= 1'b1;
					busy <= 1'b0;
					gamma1Sf0 <= g1Pend[0];
					gamma1Sf1 <= g1Pend[1];
					gamma2Sf0 <= g2Pend[0];
					gamma2Sf1 <= g2Pend[1];
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Captured LARs and pending gammas
	always_ff @(posedge clk)
	begin
		if (state == convert1)
			larNew0 <= lar;
		if ((state == decide) && !sf)
			larNew1 <= lar;
		if (state == decide)
		begin
			g1Pend[sf] <= smoothNext ? gamma1Smooth : gamma1Rough;
			if (smoothNext)
				g2Pend[sf] <= gamma2Smooth;
		end
		if (state == gammaCalc)
			g2Pend[sf] <= g2Clamp;
	end

endmodule

// ==== percVarPkg.sv ====
package percVarPkg;

	//////////////////////////////////////////////////////////////////////
	// Word types and sizes
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	localparam int lpcOrder = 10;	// Default LPC order

	//////////////////////////////////////////////////////////////////////
	// Fixed-point constants of the LAR approximation and gamma rules
	//////////////////////////////////////////////////////////////////////

	localparam word16 seg1 = 16'sd1299;	// Breakpoints on |rc| >> 4
	localparam word16 seg2 = 16'sd1815;
	localparam word16 seg3 = 16'sd1944;

	localparam word16 slopeA1 = 16'sd4567;
	localparam word16 slopeA2 = 16'sd11776;
	localparam word16 slopeA3 = 16'sd27443;
	localparam word32 offsetB1 = 32'sd3271557;
	localparam word32 offsetB2 = 32'sd16357786;
	localparam word32 offsetB3 = 32'sd46808433;

	localparam word16 threshL1 = -16'sd3562;	// Leave smoothing
	localparam word16 threshH1 = 16'sd1336;
	localparam word16 threshL2 = -16'sd3116;	// Re-enter smoothing
	localparam word16 threshH2 = 16'sd890;

	localparam word16 gamma1Rough = 16'sd32113;
	localparam word16 gamma1Smooth = 16'sd30802;
	localparam word16 gamma2Max = 16'sd22938;
	localparam word16 gamma2Min = 16'sd13107;
	localparam word16 gamma2Smooth = 16'sd19661;

	localparam word16 alpha = 16'sd19302;	// Gap to gamma2 slope
	localparam word16 beta = 16'sd1024;

	typedef enum logic [2:0] {
		idle,
		convert0,
		convert1,
		decide,
		gapRun,
		gammaCalc,
		finish
	} ctrlState;

	//////////////////////////////////////////////////////////////////////
	// Saturating arithmetic
	//////////////////////////////////////////////////////////////////////

	function automatic word16 sat16(input word32 x);
		if (x > 32'sd32767)
			return 16'sd32767;
		else if (x < -32'sd32768)
			return -16'sd32768;
		else
			return word16'(x);
	endfunction

	function automatic word16 satAdd16(input word16 a, input word16 b);
		return sat16(word32'(a) + word32'(b));
	endfunction

	function automatic word16 satSub16(input word16 a, input word16 b);
		return sat16(word32'(a) - word32'(b));
	endfunction

	// Left shift by n, clipped to the 16-bit range
	function automatic word16 shl16(input word16 a, input int n);
		return sat16(word32'(a) <<< n);
	endfunction

	function automatic word16 mult16(input word16 a, input word16 b);
		word32 prod;
		prod = word32'(a) * word32'(b);
		return sat16(prod >>> 15);	// Q15 product, -1 * -1 clips
	endfunction

endpackage

// ==== percVar_sva.sv ====
`timescale 1ns/1ns

module percVarSva import percVarPkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic start,
	input  logic busy,
	input  logic done,
	input  word16 gamma2Sf0,
	input  word16 gamma2Sf1
);

	int failCount = 0;	// Failed assertions so far
	logic haveResult;	// Gamma outputs hold a computed frame

	always_ff @(posedge clk)
	begin
		if (reset)
			haveResult <= 1'b0;
		else if (done)
			haveResult <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Strobe protocol
	//////////////////////////////////////////////////////////////////////

	doneSingle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
	else
	begin
		$error("done stayed high for more than one cycle");
		failCount++;
	end

	doneEndsBusy: assert property (@(posedge clk) disable iff (reset)
		done |-> (!busy && $past(busy)))
	else
	begin
		$error("done did not coincide with the fall of busy");
		failCount++;
	end

	busyAfterStart: assert property (@(posedge clk) disable iff (reset)
		(start && !busy) |=> busy)
	else
	begin
		$error("busy did not rise after an accepted start");
		failCount++;
	end

	noLoadBusy: assert property (@(posedge clk) disable iff (reset) busy |-> !load)
	else
	begin
		$error("frame store written while a frame was running");
		failCount++;
	end

	// Both gamma2 words stay inside the clamp window once computed
	gamma2Range: assert property (@(posedge clk) disable iff (reset)
		haveResult |-> ((gamma2Sf0 >= gamma2Min) && (gamma2Sf0 <= gamma2Max)
			&& (gamma2Sf1 >= gamma2Min) && (gamma2Sf1 <= gamma2Max)))
	else
	begin
		$error("gamma2 output left the range gamma2Min to gamma2Max");
		failCount++;
	end

endmodule

bind percVar percVarSva uSva (
	.clk(clk), .reset(reset), .load(load), .start(start),
	.busy(busy), .done(done), .gamma2Sf0(gamma2Sf0), .gamma2Sf1(gamma2Sf1)
);

// ==== tb_percVar.sv ====
`timescale 1ns/1ns

module tb_percVar import percVarPkg::*; ();

	localparam int order = lpcOrder;
	localparam int clkPeriod = 10;
	localparam int doneTimeout = 60;	// Cycles from start to done
	localparam int watchdogCycles = 8 + 40 * 60;	// 40 frames of 60 cycles

	logic clk;
	logic reset;
	logic load;
	logic [4:0] loadAddr;
	word16 loadData;
	logic start;
	logic busy;
	logic done;
	word16 gamma1Sf0;
	word16 gamma1Sf1;
	word16 gamma2Sf0;
	word16 gamma2Sf1;

	word16 frameRc [2];
	word16 frameLsf [2][order];	// Interpolated set, then new set
	word16 expG1 [2];
	word16 expG2 [2];
	word16 modelPrev0;
	word16 modelPrev1;
	logic modelSmooth;
	integer seed;
	int errorCount;
	int checkCount;
	int testCount;
	int frameCount;
	int testErrBase;
	int totalErrors;

	percVar #(.order(order)) u_dut (
		.clk(clk), .reset(reset), .load(load), .loadAddr(loadAddr), .loadData(loadData),
		.start(start), .busy(busy), .done(done),
		.gamma1Sf0(gamma1Sf0), .gamma1Sf1(gamma1Sf1),
		.gamma2Sf0(gamma2Sf0), .gamma2Sf1(gamma2Sf1)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: run still going after %0d cycles", watchdogCycles);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic word16 larOfCoef(input word16 rc);
		word16 mag;
		word16 sh;
		word16 slope;
		word32 offset;
		word32 acc;
		word16 res;
		mag = (rc < 0) ? satSub16(16'sd0, rc) : rc;
		sh = mag >>> 4;
		if (sh > seg3)
		begin
			slope = slopeA3;
			offset = offsetB3;
		end
		else if (sh > seg2)
		begin
			slope = slopeA2;
			offset = offsetB2;
		end
		else
		begin
			slope = slopeA1;
			offset = offsetB1;
		end
		acc = 32'sd2 * word32'(sh >>> 1) * word32'(slope) - offset;
		res = (sh <= seg1) ? sh : word16'(acc >>> 11);
		return (rc < 0) ? satSub16(16'sd0, res) : res;	// Sign back on
	endfunction

	function automatic word16 minDoubledGap(input int s);
		word16 best;
		word16 g;
		best = 16'sd32767;
		for (int i = 0; i < order - 1; i++)
		begin
			g = satSub16(shl16(frameLsf[s][i + 1], 1), shl16(frameLsf[s][i], 1));
			if (g < best)
				best = g;
		end
		return best;
	endfunction

	function automatic word16 gamma2FromGap(input word16 d);
		word16 g;
		g = shl16(satSub16(beta, mult16(alpha, d)), 5);
		if (g > gamma2Max)
			return gamma2Max;
		if (g < gamma2Min)
			return gamma2Min;
		return g;
	endfunction

	function automatic word16 frameWord(input int addr);
		if (addr < 2)
			return frameRc[addr];
		if (addr < 2 + order)
			return frameLsf[0][addr - 2];
		return frameLsf[1][addr - 2 - order];
	endfunction

	// Expected gammas for the loaded frame, model state moves on
	task automatic predictFrame();
		word16 newLar0;
		word16 newLar1;
		word16 c0;
		word16 c1;
		newLar0 = larOfCoef(frameRc[0]);
		newLar1 = larOfCoef(frameRc[1]);
		for (int sf = 0; sf < 2; sf++)
		begin
			c0 = (sf == 0) ? (satAdd16(newLar0, modelPrev0) >>> 1) : newLar0;
			c1 = (sf == 0) ? (satAdd16(newLar1, modelPrev1) >>> 1) : newLar1;
			if (modelSmooth && (c0 < threshL1) && (c1 > threshH1))
				modelSmooth = 1'b0;
			else if (!modelSmooth && ((c0 > threshL2) || (c1 < threshH2)))
				modelSmooth = 1'b1;
			expG1[sf] = modelSmooth ? gamma1Smooth : gamma1Rough;
			expG2[sf] = modelSmooth ? gamma2Smooth : gamma2FromGap(minDoubledGap(sf));
		end
		modelPrev0 = newLar0;
		modelPrev1 = newLar1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic fillRandomSet(input int s);
		word16 tmp;
		for (int i = 0; i < order; i++)
			frameLsf[s][i] = word16'($random(seed) & 32'h3fff);
		for (int i = 0; i < order - 1; i++)	// Ascending order
			for (int j = 0; j < order - 1 - i; j++)
				if (frameLsf[s][j] > frameLsf[s][j + 1])
				begin
					tmp = frameLsf[s][j];
					frameLsf[s][j] = frameLsf[s][j + 1];
					frameLsf[s][j + 1] = tmp;
				end
	endtask

	// Jitter stays below the step so the set remains ascending
	task automatic fillSpacedSet(input int s, input int base, input int step);
		for (int i = 0; i < order; i++)
			frameLsf[s][i] = word16'(base + i * step + ($random(seed) & 31));
	endtask

	task automatic setCoefs(input word16 rc0, input word16 rc1);
		frameRc[0] = rc0;
		frameRc[1] = rc1;
	endtask

	task automatic loadFrame();
		for (int a = 0; a < 2 + 2 * order; a++)
		begin
			@(posedge clk);
			#1;
			load = 1'b1;
			loadAddr = 5'(a);
			loadData = frameWord(a);
		end
		@(posedge clk);
		#1;
		load = 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic waitDone(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && (n < doneTimeout))
		begin
			@(posedge clk);
			#1;
			seen = done;
			n++;
		end
		checkCount++;
		assert (seen)
		else
		begin
			$display("No done pulse within %0d cycles of start, at %0t ns", doneTimeout, $time);
			errorCount++;
		end
	endtask

	task automatic checkWord(input string name, input word16 got, input word16 expected);
		checkCount++;
		assert (got == expected)
		else
		begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
			errorCount++;
		end
	endtask

	task automatic compareGammas();
		checkWord("gamma1Sf0", gamma1Sf0, expG1[0]);
		checkWord("gamma1Sf1", gamma1Sf1, expG1[1]);
		checkWord("gamma2Sf0", gamma2Sf0, expG2[0]);
		checkWord("gamma2Sf1", gamma2Sf1, expG2[1]);
	endtask

	task automatic runFrame();
		logic seen;
		loadFrame();
		predictFrame();
		pulseStart();
		waitDone(seen);
		if (seen)
			compareGammas();
		frameCount++;
	endtask

	task automatic resetStateTest();
		checkCount++;
		assert (!busy && !done)
		else
		begin
			$display("busy or done high after reset");
			errorCount++;
		end
		expG1 = '{16'sd0, 16'sd0};
		expG2 = '{16'sd0, 16'sd0};
		compareGammas();
	endtask

	// Second start lands while the frame is running and must be dropped
	task automatic strobeTest();
		logic seen;
		int extraDone;
		setCoefs(-16'sd32000, 16'sd26000);
		fillSpacedSet(0, 600, 380);
		fillSpacedSet(1, 300, 150);
		loadFrame();
		predictFrame();
		pulseStart();
		@(posedge clk);
		#1;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		waitDone(seen);
		if (seen)
			compareGammas();
		extraDone = 0;
		repeat (30)
		begin
			@(posedge clk);
			#1;
			if (done || busy)
				extraDone++;
		end
		checkCount++;
		assert (extraDone == 0)
		else
		begin
			$display("Start while busy was taken, %0d cycles of extra activity", extraDone);
			errorCount++;
		end
		frameCount++;
	endtask

	task automatic endTest(input string name);
		$display("Test %s finished: %0d frames, %0d errors", name, frameCount,
			errorCount - testErrBase);
		testCount++;
		frameCount = 0;
		testErrBase = errorCount;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		load = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		seed = 32'h46c2;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		frameCount = 0;
		testErrBase = 0;
		modelSmooth = 1'b1;	// Model starts like the DUT after reset
		modelPrev0 = '0;
		modelPrev1 = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		resetStateTest();
		endTest("resetState");

		for (int f = 0; f < 2; f++)
		begin
			setCoefs(word16'($random(seed) % 2048), word16'($random(seed) % 2048));
			fillRandomSet(0);
			fillRandomSet(1);
			runFrame();
		end
		endTest("smoothPath");

		for (int f = 0; f < 3; f++)
		begin
			setCoefs(-16'sd32000, 16'sd26000);	// LAR0 near -3944, LAR1 near 2024
			fillSpacedSet(0, 500 + 40 * f, 380);
			fillSpacedSet(1, 900, 350 + 20 * f);
			runFrame();
		end
		endTest("roughPath");

		fillSpacedSet(0, 1000, 150);
		fillSpacedSet(1, 400, 1400);
		runFrame();
		fillSpacedSet(0, 400, 1400);
		fillSpacedSet(1, 1000, 150);
		runFrame();
		endTest("clamps");

		setCoefs(16'sd1000, -16'sd1000);	// Back to smoothing via threshL2
		fillRandomSet(0);
		fillRandomSet(1);
		runFrame();
		setCoefs(-16'sd32000, 16'sd26000);
		fillSpacedSet(1, 700, 400);
		runFrame();
		setCoefs(-16'sd24000, 16'sd10000);
		runFrame();
		setCoefs(-16'sd32000, 16'sd26000);
		runFrame();
		setCoefs(-16'sd32000, 16'sd3000);	// Small LAR1 trips threshH2
		fillRandomSet(0);
		runFrame();
		setCoefs(-16'sd32000, 16'sd26000);
		runFrame();
		endTest("memoryFrames");

		strobeTest();
		endTest("controlStrobes");

		for (int f = 0; f < 8; f++)
		begin
			setCoefs(word16'($random(seed)), word16'($random(seed)));
			fillRandomSet(0);
			if (f % 2 == 0)
				fillRandomSet(1);
			else
				fillSpacedSet(1, 200 + 10 * f, 300 + 30 * f);
			runFrame();
		end
		endTest("randomFrames");

		totalErrors = errorCount + u_dut.uSva.failCount;
		$display("Tests: %0d, checks: %0d, check errors: %0d, assertion failures: %0d",
			testCount, checkCount, errorCount, u_dut.uSva.failCount);
		if (totalErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
percVarPkg.sv
frameStore.sv
larConvert.sv
lsfMinGap.sv
percVarCtrl.sv
percVar.sv
percVar_sva.sv
tb_percVar.sv
